/* rtl/ticTacToePkg.sv */
package ticTacToePkg;

	typedef enum logic [1:0] {
		EMPTY = 2'd0,
		CROSS = 2'd1,
		NOUGHT = 2'd2
	} cellState;

	// Cell 0 is top-left, cell 8 bottom-right.
	typedef cellState [8:0] boardState;

	// Row 0 on top, bit 15 is the leftmost column.
	typedef logic [15:0][15:0] pixelFrame;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic place;
		logic newGame;
	} buttonSet;

	typedef struct packed {
		cellState winner;
		cellState turn;
		logic draw;
	} gameStatus;

	localparam int ROW_HOLD = 4; // Clock cycles per displayed row.
	localparam int ROW_COUNT = 16;

	localparam boardState EMPTY_BOARD = '{default: EMPTY};

	// Rows, columns, then the two diagonals.
	localparam logic [3:0] WIN_LINES [8][3] = '{
		'{4'd0, 4'd1, 4'd2}, '{4'd3, 4'd4, 4'd5}, '{4'd6, 4'd7, 4'd8},
		'{4'd0, 4'd3, 4'd6}, '{4'd1, 4'd4, 4'd7}, '{4'd2, 4'd5, 4'd8},
		'{4'd0, 4'd4, 4'd8}, '{4'd2, 4'd4, 4'd6}
	};

	// Mark rows, written for the 6-bit band. Narrow bands use the low five bits.
	localparam logic [5:0] CROSS_ROWS [4] = '{6'b010010, 6'b001100, 6'b001100, 6'b010010};
	localparam logic [5:0] NOUGHT_ROWS [4] = '{6'b001100, 6'b010010, 6'b010010, 6'b001100};

	localparam int BAND_TOP [3] = '{0, 6, 11};
	localparam int MARK_TOP [3] = '{1, 6, 11}; // First patterned row of each band.
	localparam int BAND_LEFT [3] = '{15, 9, 4};
	localparam int BAND_RIGHT [3] = '{10, 5, 0};
	localparam int BAND_WIDTH [3] = '{6, 5, 5};

	localparam int GRID_ROWS [2] = '{5, 10};
	localparam int GRID_COLUMNS [2] = '{10, 5};

endpackage

/* rtl/buttonEdge.sv */
`timescale 1ns/1ps

module buttonEdge (
	input logic clk,
	input logic reset,
	input ticTacToePkg::buttonSet buttons,
	output ticTacToePkg::buttonSet presses
);

	ticTacToePkg::buttonSet syncFirst;
	ticTacToePkg::buttonSet syncSecond;
	ticTacToePkg::buttonSet previous;

	always_ff @(posedge clk) begin
		if (reset) begin
			syncFirst <= '0;
			syncSecond <= '0;
			previous <= '0;
			presses <= '0;
		end else begin
			syncFirst <= buttons;
			syncSecond <= syncFirst;
			previous <= syncSecond;
			// High now, low the cycle before.
			presses <= ticTacToePkg::buttonSet'(syncSecond & ~previous);
		end
	end

endmodule

/* rtl/gameController.sv */
`timescale 1ns/1ps

module gameController (
	input logic clk,
	input logic reset,
	input ticTacToePkg::buttonSet presses,
	input ticTacToePkg::cellState winner,
	output ticTacToePkg::boardState board,
	output logic [3:0] cursor,
	output ticTacToePkg::cellState turn
);

	logic [1:0] cursorRow;
	logic [1:0] cursorColumn;
	logic canPlace;

	// Wrapping steps within one row or column of three.
	function automatic logic [1:0] stepBack(logic [1:0] position);
		return (position == 2'd0) ? 2'd2 : position - 2'd1;
	endfunction

	function automatic logic [1:0] stepForward(logic [1:0] position);
		return (position == 2'd2) ? 2'd0 : position + 2'd1;
	endfunction

	assign cursor = {2'b00, cursorRow} * 4'd3 + {2'b00, cursorColumn};

	// No moves once somebody has won.
	assign canPlace = (board[cursor] == ticTacToePkg::EMPTY) &&
		(winner == ticTacToePkg::EMPTY);

	always_ff @(posedge clk) begin
		if (reset) begin
			board <= ticTacToePkg::EMPTY_BOARD;
			turn <= ticTacToePkg::CROSS;
			cursorRow <= 2'd0;
			cursorColumn <= 2'd0;
		end else if (presses.newGame) begin
			board <= ticTacToePkg::EMPTY_BOARD; // Cursor stays where it is.
			turn <= ticTacToePkg::CROSS;
		end else if (presses.place) begin
			if (canPlace) begin
				board[cursor] <= turn;
				turn <= (turn == ticTacToePkg::CROSS) ? ticTacToePkg::NOUGHT :
					ticTacToePkg::CROSS;
			end
		end else if (presses.up) begin
			cursorRow <= stepBack(cursorRow);
		end else if (presses.down) begin
			cursorRow <= stepForward(cursorRow);
		end else if (presses.left) begin
			cursorColumn <= stepBack(cursorColumn);
		end else if (presses.right) begin
			cursorColumn <= stepForward(cursorColumn);
		end
	end

endmodule

/* rtl/winChecker.sv */
`timescale 1ns/1ps

module winChecker (
	input ticTacToePkg::boardState board,
	output ticTacToePkg::cellState winner,
	output logic draw
);

	logic boardFull;

	// Walk backwards so the first matching line is the one that sticks.
	always_comb begin
		winner = ticTacToePkg::EMPTY;
		for (int line = 7; line >= 0; line--) begin
			if (board[ticTacToePkg::WIN_LINES[line][0]] != ticTacToePkg::EMPTY &&
				board[ticTacToePkg::WIN_LINES[line][0]] ==
					board[ticTacToePkg::WIN_LINES[line][1]] &&
				board[ticTacToePkg::WIN_LINES[line][1]] ==
					board[ticTacToePkg::WIN_LINES[line][2]]) begin
				winner = board[ticTacToePkg::WIN_LINES[line][0]];
			end
		end
	end

	always_comb begin
		boardFull = 1'b1;
		for (int cellIndex = 0; cellIndex < 9; cellIndex++) begin
			if (board[cellIndex] == ticTacToePkg::EMPTY) begin
				boardFull = 1'b0;
			end
		end
	end

	assign draw = boardFull && (winner == ticTacToePkg::EMPTY); // A last-move win is no draw.

endmodule

/* rtl/gridPainter.sv */
`timescale 1ns/1ps

module gridPainter (
	input logic [3:0] cursor,
	input ticTacToePkg::cellState winner,
	output ticTacToePkg::pixelFrame redBase,
	output ticTacToePkg::pixelFrame greenFrame
);

	ticTacToePkg::pixelFrame gridLines;

	always_comb begin
		gridLines = '0;
		for (int row = 0; row < ticTacToePkg::ROW_COUNT; row++) begin
			for (int line = 0; line < 2; line++) begin
				gridLines[row][ticTacToePkg::GRID_COLUMNS[line]] = 1'b1;
			end
		end
		for (int line = 0; line < 2; line++) begin
			gridLines[ticTacToePkg::GRID_ROWS[line]] = '1;
		end
	end

	// Cursor lights the top-left pixel of its cell.
	always_comb begin
		greenFrame = gridLines;
		for (int cellIndex = 0; cellIndex < 9; cellIndex++) begin
			if (cursor == 4'(cellIndex)) begin
				greenFrame[ticTacToePkg::BAND_TOP[cellIndex / 3]]
					[ticTacToePkg::BAND_LEFT[cellIndex % 3]] = 1'b1;
			end
		end
	end

	// Grid turns red once the game is won.
	assign redBase = (winner != ticTacToePkg::EMPTY) ? gridLines : '0;

endmodule

/* rtl/cellSelector.sv */
`timescale 1ns/1ps

module cellSelector (
	input logic reset,
	input ticTacToePkg::boardState board,
	input ticTacToePkg::pixelFrame redBase,
	output ticTacToePkg::pixelFrame redPixels
);

	// One row of a mark, placed in its column band.
	function automatic logic [15:0] markBits(ticTacToePkg::cellState state, int line, int band);
		logic [5:0] pattern;
		logic [5:0] bandMask;
		case (state)
			ticTacToePkg::CROSS: pattern = ticTacToePkg::CROSS_ROWS[line];
			ticTacToePkg::NOUGHT: pattern = ticTacToePkg::NOUGHT_ROWS[line];
			default: pattern = 6'b000000; // Empty and the unused code.
		endcase
		bandMask = 6'b111111 >> (6 - ticTacToePkg::BAND_WIDTH[band]);
		return 16'(pattern & bandMask) << ticTacToePkg::BAND_RIGHT[band];
	endfunction

	always_comb begin
		redPixels = redBase;
		if (!reset) begin
			for (int cellIndex = 0; cellIndex < 9; cellIndex++) begin
				for (int line = 0; line < 4; line++) begin
					redPixels[ticTacToePkg::MARK_TOP[cellIndex / 3] + line] =
						redPixels[ticTacToePkg::MARK_TOP[cellIndex / 3] + line] |
						markBits(board[cellIndex], line, cellIndex % 3);
				end
			end
		end
	end

endmodule

/* rtl/rowScanner.sv */
`timescale 1ns/1ps

module rowScanner (
	input logic clk,
	input logic reset,
	input ticTacToePkg::pixelFrame redFrame,
	input ticTacToePkg::pixelFrame greenFrame,
	output logic [15:0] rowSelect,
	output logic [15:0] redColumn,
	output logic [15:0] greenColumn
);

	logic [$clog2(ticTacToePkg::ROW_HOLD + 1) - 1:0] holdCount;
	logic [3:0] rowIndex;
	logic [3:0] nextRow;
	logic rowChange;

	// An empty select means the scan has not started yet.
	assign rowChange = (rowSelect == '0) || (int'(holdCount) == ticTacToePkg::ROW_HOLD - 1);

	always_comb begin
		if (rowSelect == '0 || int'(rowIndex) == ticTacToePkg::ROW_COUNT - 1) begin
			nextRow = 4'd0;
		end else begin
			nextRow = rowIndex + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			holdCount <= '0;
			rowIndex <= 4'd0;
			rowSelect <= '0;
		end else if (rowChange) begin
			holdCount <= '0;
			rowIndex <= nextRow;
			rowSelect <= 16'd1 << nextRow;
		end else begin
			holdCount <= holdCount + 1'b1;
		end
	end

	// Columns follow the select in the same cycle.
	always_ff @(posedge clk) begin
		if (rowChange) begin
			redColumn <= redFrame[nextRow];
			greenColumn <= greenFrame[nextRow];
		end
	end

endmodule

/* rtl/ticTacToe.sv */
`timescale 1ns/1ps

module ticTacToe (
	input logic clk,
	input logic reset,
	input ticTacToePkg::buttonSet buttons,
	output ticTacToePkg::gameStatus status,
	output logic [15:0] rowSelect,
	output logic [15:0] redColumn,
	output logic [15:0] greenColumn
);

	ticTacToePkg::buttonSet presses;
	ticTacToePkg::boardState board;
	ticTacToePkg::cellState turn;
	ticTacToePkg::cellState winner;
	ticTacToePkg::pixelFrame redBase;
	ticTacToePkg::pixelFrame redFrame;
	ticTacToePkg::pixelFrame greenFrame;
	logic [3:0] cursor;
	logic draw;

	buttonEdge buttonEdge_i (
		.clk(clk),
		.reset(reset),
		.buttons(buttons),
		.presses(presses)
	);

	gameController gameController_i (
		.clk(clk),
		.reset(reset),
		.presses(presses),
		.winner(winner),
		.board(board),
		.cursor(cursor),
		.turn(turn)
	);

	winChecker winChecker_i (
		.board(board),
		.winner(winner),
		.draw(draw)
	);

	gridPainter gridPainter_i (
		.cursor(cursor),
		.winner(winner),
		.redBase(redBase),
		.greenFrame(greenFrame)
	);

	cellSelector cellSelector_i (
		.reset(reset),
		.board(board),
		.redBase(redBase),
		.redPixels(redFrame)
	);

	rowScanner rowScanner_i (
		.clk(clk),
		.reset(reset),
		.redFrame(redFrame),
		.greenFrame(greenFrame),
		.rowSelect(rowSelect),
		.redColumn(redColumn),
		.greenColumn(greenColumn)
	);

	assign status = '{winner: winner, turn: turn, draw: draw};

endmodule

/* tests/ticTacToeModel.svh */
`ifndef TIC_TAC_TOE_MODEL_SVH
`define TIC_TAC_TOE_MODEL_SVH

// Cells hold 0 for empty, 1 for cross and 2 for nought.
typedef int cellArray [9];

function automatic int lineOwner(cellArray cells, int a, int b, int c);
	return (cells[a] == cells[b] && cells[b] == cells[c]) ? cells[a] : 0;
endfunction

function automatic int modelWinner(cellArray cells);
	int found;
	found = 0;
	for (int i = 0; i < 3; i++) begin
		if (found == 0) begin
			found = lineOwner(cells, 3 * i, 3 * i + 1, 3 * i + 2);
		end
		if (found == 0) begin
			found = lineOwner(cells, i, i + 3, i + 6);
		end
	end
	if (found == 0) begin
		found = lineOwner(cells, 0, 4, 8);
	end
	if (found == 0) begin
		found = lineOwner(cells, 2, 4, 6);
	end
	return found;
endfunction

function automatic int modelDraw(cellArray cells);
	int full;
	full = 1;
	foreach (cells[c]) begin
		if (cells[c] == 0) begin
			full = 0;
		end
	end
	return (full == 1 && modelWinner(cells) == 0) ? 1 : 0;
endfunction

// Rows 5 and 10, columns 10 and 5.
function automatic ticTacToePkg::pixelFrame gridFrame();
	ticTacToePkg::pixelFrame frame;
	for (int r = 0; r < 16; r++) begin
		frame[r] = (r == 5 || r == 10) ? 16'hffff : 16'h0420;
	end
	return frame;
endfunction

function automatic logic [15:0] markRow(int state, int line, int band);
	logic [5:0] wide;
	logic [4:0] narrow;
	logic outer;
	outer = (line == 0 || line == 3);
	wide = '0;
	narrow = '0;
	if (state == 1) begin
		wide = outer ? 6'b010010 : 6'b001100;
		narrow = outer ? 5'b10010 : 5'b01100;
	end else if (state == 2) begin
		wide = outer ? 6'b001100 : 6'b010010;
		narrow = outer ? 5'b01100 : 5'b10010;
	end
	if (band == 0) begin
		return {wide, 10'b0};
	end
	return (band == 1) ? {6'b0, narrow, 5'b0} : {11'b0, narrow};
endfunction

function automatic ticTacToePkg::pixelFrame modelRed(cellArray cells, int winner);
	ticTacToePkg::pixelFrame frame;
	int top;
	frame = (winner != 0) ? gridFrame() : '0;
	for (int c = 0; c < 9; c++) begin
		top = (c / 3 == 0) ? 1 : (c / 3 == 1) ? 6 : 11; // First patterned row.
		for (int line = 0; line < 4; line++) begin
			frame[top + line] = frame[top + line] | markRow(cells[c], line, c % 3);
		end
	end
	return frame;
endfunction

function automatic ticTacToePkg::pixelFrame modelGreen(int cursorCell);
	ticTacToePkg::pixelFrame frame;
	int top;
	int left;
	frame = gridFrame();
	top = (cursorCell / 3 == 0) ? 0 : (cursorCell / 3 == 1) ? 6 : 11;
	left = (cursorCell % 3 == 0) ? 15 : (cursorCell % 3 == 1) ? 9 : 4;
	frame[top][left] = 1'b1;
	return frame;
endfunction

`endif

/* tests/ticTacToeTb.sv */
`timescale 1ns/1ps

module ticTacToeTb;

	`include "ticTacToeModel.svh"

	typedef enum int {MOVE_UP, MOVE_DOWN, MOVE_LEFT, MOVE_RIGHT, PLACE_MARK, NEW_GAME} pressKind;

	logic clk;
	logic reset;
	ticTacToePkg::buttonSet buttons;
	ticTacToePkg::gameStatus status;
	logic [15:0] rowSelect;
	logic [15:0] redColumn;
	logic [15:0] greenColumn;

	cellArray board; // Expected game state.
	int cursorCell;
	int turn;
	int seed;

	logic [15:0] redRows [16];
	logic [15:0] greenRows [16];
	int loadStamp [16]; // Load number that last refreshed each row.
	int loadCount = 0;
	int holdCycles = 0;
	logic [15:0] lastSelect = '0;

	ticTacToe ticTacToe_i (
		.clk(clk),
		.reset(reset),
		.buttons(buttons),
		.status(status),
		.rowSelect(rowSelect),
		.redColumn(redColumn),
		.greenColumn(greenColumn)
	);

	always #2 clk = ~clk;

	task automatic stopWithFailure();
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic compareValue(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
			stopWithFailure();
		end
	endtask

	// Row capture. A new select must be the next row after a full hold.
	always @(negedge clk) begin
		int row;
		if (rowSelect != lastSelect) begin
			if (lastSelect == '0) begin
				compareValue("rowSelect", 32'h1, rowSelect);
			end else begin
				compareValue("rowSelect", {lastSelect[14:0], lastSelect[15]}, rowSelect);
				compareValue("row hold cycles", ticTacToePkg::ROW_HOLD, holdCycles);
			end
			row = 0;
			for (int r = 0; r < 16; r++) begin
				if (rowSelect[r]) begin
					row = r;
				end
			end
			redRows[row] = redColumn;
			greenRows[row] = greenColumn;
			loadCount++;
			loadStamp[row] = loadCount;
			holdCycles = 1;
		end else begin
			holdCycles++;
		end
		lastSelect = rowSelect;
	end

	function automatic void applyModel(pressKind kind);
		int row;
		int column;
		row = cursorCell / 3;
		column = cursorCell % 3;
		case (kind)
			NEW_GAME: begin
				foreach (board[c]) begin
					board[c] = 0;
				end
				turn = 1;
			end
			PLACE_MARK: begin
				if (board[cursorCell] == 0 && modelWinner(board) == 0) begin
					board[cursorCell] = turn;
					turn = 3 - turn;
				end
			end
			MOVE_UP: row = (row + 2) % 3;
			MOVE_DOWN: row = (row + 1) % 3;
			MOVE_LEFT: column = (column + 2) % 3;
			default: column = (column + 1) % 3;
		endcase
		cursorCell = row * 3 + column;
	endfunction

	task automatic checkState();
		ticTacToePkg::pixelFrame expectedRed;
		ticTacToePkg::pixelFrame expectedGreen;
		int winner;
		int startCount;
		int waited;
		bit allFresh;
		winner = modelWinner(board);
		expectedRed = modelRed(board, winner);
		expectedGreen = modelGreen(cursorCell);
		compareValue("status.winner", winner, status.winner);
		compareValue("status.turn", turn, status.turn);
		compareValue("status.draw", modelDraw(board), status.draw);
		startCount = loadCount;
		waited = 0;
		allFresh = 1'b0;
		while (!allFresh) begin
			@(negedge clk);
			waited++;
			if (waited > 200) begin
				$display("Timeout: the row scan did not refresh all 16 rows within 200 cycles");
				stopWithFailure();
			end
			allFresh = 1'b1;
			foreach (loadStamp[r]) begin
				if (loadStamp[r] <= startCount) begin
					allFresh = 1'b0;
				end
			end
		end
		for (int r = 0; r < 16; r++) begin
			compareValue($sformatf("redColumn row %0d", r), expectedRed[r], redRows[r]);
			compareValue($sformatf("greenColumn row %0d", r), expectedGreen[r], greenRows[r]);
		end
	endtask

	// Five cycles high, five low.
	task automatic pressButton(pressKind kind);
		@(negedge clk);
		case (kind)
			MOVE_UP: buttons.up = 1'b1;
			MOVE_DOWN: buttons.down = 1'b1;
			MOVE_LEFT: buttons.left = 1'b1;
			MOVE_RIGHT: buttons.right = 1'b1;
			PLACE_MARK: buttons.place = 1'b1;
			default: buttons.newGame = 1'b1;
		endcase
		repeat (5) @(negedge clk);
		buttons = '0;
		repeat (5) @(negedge clk);
		applyModel(kind);
		checkState();
	endtask

	task automatic placeAt(int target);
		while (cursorCell / 3 != target / 3) begin
			pressButton(MOVE_DOWN);
		end
		while (cursorCell % 3 != target % 3) begin
			pressButton(MOVE_RIGHT);
		end
		pressButton(PLACE_MARK);
	endtask

	task automatic playGame(int cells [$]);
		foreach (cells[i]) begin
			placeAt(cells[i]);
		end
	endtask

	initial begin
		int moves [$];
		int pick;
		clk = 1'b0;
		reset = 1'b1;
		buttons = '0;
		seed = 32'h894c_642a;
		cursorCell = 0;
		turn = 1;
		foreach (board[c]) begin
			board[c] = 0;
		end
		foreach (loadStamp[r]) begin
			loadStamp[r] = 0;
		end
		repeat (3) begin
			@(negedge clk);
			compareValue("rowSelect", 32'h0, rowSelect); // Dark during reset.
		end
		reset = 1'b0;
		checkState();

		// Three steps in one direction wrap back to cell 0.
		for (int kind = MOVE_UP; kind <= MOVE_RIGHT; kind++) begin
			repeat (3) pressButton(pressKind'(kind));
		end

		moves = '{0, 1};
		playGame(moves);
		pressButton(PLACE_MARK); // Occupied cell.
		placeAt(0);
		pressButton(NEW_GAME);

		moves = '{0, 3, 1, 4, 2};
		playGame(moves);
		compareValue("status.winner", 1, status.winner);
		placeAt(5);
		pressButton(NEW_GAME);

		moves = '{0, 1, 2, 4, 3, 7}; // Middle column for nought.
		playGame(moves);
		compareValue("status.winner", 2, status.winner);
		placeAt(8);
		pressButton(NEW_GAME);

		moves = '{0, 1, 4, 2, 8};
		playGame(moves);
		compareValue("status.winner", 1, status.winner);
		placeAt(6);
		pressButton(NEW_GAME);

		moves = '{0, 1, 2, 4, 3, 5, 7, 6, 8};
		playGame(moves);
		compareValue("status.draw", 1, status.draw);
		pressButton(NEW_GAME);

		// Random play that mostly places so games reach an end.
		for (int i = 0; i < 200; i++) begin
			pick = $unsigned($random(seed)) % 10;
			if (pick < 4) begin
				pressButton(pressKind'(pick));
			end else if (pick < 9) begin
				pressButton(PLACE_MARK);
			end else begin
				pressButton(NEW_GAME);
			end
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* ticTacToe.f */
+incdir+tests
rtl/ticTacToePkg.sv
rtl/buttonEdge.sv
rtl/gameController.sv
rtl/winChecker.sv
rtl/gridPainter.sv
rtl/cellSelector.sv
rtl/rowScanner.sv
rtl/ticTacToe.sv
tests/ticTacToeTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= ticTacToeTb
FILELIST ?= ticTacToe.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -Wno-fatal
PASS_TEXT = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
